// File: common/mm_config.svh
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// ------------------------------
// datapath shape
// ------------------------------
`define SIMD_LANES     4                   // words per beat
`define LOG_SIMD_LANES 2                   // log2 of the lane count
`define WORD_W         32                  // data word width

// A and C word address, 512-word max size over 4 lanes
`define ADDR_W         (9 - `LOG_SIMD_LANES)

// ------------------------------
// pipeline timing
// ------------------------------
`define MULT_LAT       4                   // product latency in cycles

// wait after last beat so every row total has reached the C port
`define DRAIN_WAIT     (`MULT_LAT + `LOG_SIMD_LANES + 4)

`endif

// File: common/mm_pkg.sv
`include "mm_config.svh"

package mm_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`SIMD_LANES-1:0][`WORD_W-1:0] vec_t;  // lane 0 in the low word

  // ------------------------------
  // outside ports
  // ------------------------------
  typedef struct packed {
    word_t data;                          // size, beat count or end marker
    logic  empty;
  } cmd_s;

  typedef struct packed {
    word_t data;                          // elapsed cycles
    logic  enq;                           // one-cycle push
  } stat_s;

  typedef struct packed {
    logic               we;
    logic [`ADDR_W-1:0] addr;
    vec_t               data;
  } a_load_s;

  typedef struct packed {
    vec_t data;                           // one B beat
    logic empty;
  } b_stream_s;

  typedef struct packed {
    logic               we;
    logic [`ADDR_W-1:0] addr;
    vec_t               data;             // SIMD_LANES results, first in lane 0
  } c_write_s;

  // ------------------------------
  // internal stages
  // ------------------------------
  typedef struct packed {
    logic valid;
    vec_t a;
    vec_t b;
    logic last;                           // final beat of a B row
  } beat_s;

  typedef struct packed {
    logic valid;
    vec_t sums;                           // per-lane row totals
  } lane_sums_s;

  typedef struct packed {
    logic  valid;
    word_t data;                          // one dot product
  } scalar_s;

endpackage

// File: operand_fetch/operand_fetch.sv
`timescale 1ns/1ps
`include "mm_config.svh"

module operand_fetch (
  input  logic              CLK,
  input  logic              RST,
  input  mm_pkg::cmd_s      cmd,
  output logic              cmd_deq,
  output mm_pkg::stat_s     stat,
  input  logic              stat_full,
  input  mm_pkg::a_load_s   a_load,
  input  mm_pkg::b_stream_s b,
  output logic              b_deq,
  output mm_pkg::beat_s     beat,
  output logic              new_matrix
);

  localparam int AW         = `ADDR_W;
  localparam int DRAIN_LAST = `DRAIN_WAIT - 1;

  typedef enum logic [2:0] {
    S_WAIT_SIZE, S_LATCH_SIZE, S_WAIT_COUNT, S_LATCH_COUNT, S_STREAM, S_DRAIN, S_REPORT
  } state_e;

  state_e         state;
  logic           settle;                 // high on the 2nd cycle after a pop
  mm_pkg::word_t  beats;                  // R of the running computation
  mm_pkg::word_t  deq_cnt;
  mm_pkg::word_t  cycle_cnt;
  logic [7:0]     drain_cnt;
  logic [AW-1:0]  last_addr;              // N/SIMD_LANES - 1
  logic [AW-1:0]  rd_addr;                // doubles as beat-in-row counter
  logic [AW-1:0]  ram_addr;
  mm_pkg::vec_t   a_mem [2**AW];
  mm_pkg::vec_t   a_q;
  logic           d_b_deq;                // B data returns this cycle
  logic           d_last;
  logic           beat_vld;
  logic           beat_last;
  mm_pkg::vec_t   beat_a;
  mm_pkg::vec_t   beat_b;
  mm_pkg::word_t  stat_data;
  logic           stat_enq;

  // pull B only while streaming and beats remain
  assign b_deq = (state == S_STREAM) && !b.empty && (deq_cnt != beats);

  // ------------------------------
  // A vector RAM, single port
  // ------------------------------
  assign ram_addr = a_load.we ? a_load.addr : rd_addr;   // host loads only when idle

  always_ff @(posedge CLK) begin
    if (a_load.we) begin
      a_mem[ram_addr] <= a_load.data;
    end
    a_q <= a_mem[ram_addr];               // lines up with returned B data
  end

  // ------------------------------
  // command FSM
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state      <= S_WAIT_SIZE;
      settle     <= 1'b0;
      cmd_deq    <= 1'b0;
      stat_enq   <= 1'b0;
      new_matrix <= 1'b0;
      beats      <= '0;
      deq_cnt    <= '0;
      drain_cnt  <= '0;
      last_addr  <= '0;
      rd_addr    <= '0;
    end else begin
      cmd_deq    <= 1'b0;             // strobes
      stat_enq   <= 1'b0;
      new_matrix <= 1'b0;
      if (b_deq) begin
        deq_cnt <= deq_cnt + 1'b1;
        rd_addr <= (rd_addr == last_addr) ? '0 : rd_addr + 1'b1;  // wrap per row
      end
      case (state)
        S_WAIT_SIZE: begin
          if (!cmd.empty) begin
            cmd_deq <= 1'b1;
            settle  <= 1'b0;
            state   <= S_LATCH_SIZE;
          end
        end
        S_LATCH_SIZE: begin
          settle <= 1'b1;
          if (settle) begin               // size word valid now
            last_addr  <= AW'((cmd.data >> `LOG_SIMD_LANES) - 1);
            rd_addr    <= '0;
            new_matrix <= 1'b1;
            state      <= S_WAIT_COUNT;
          end
        end
        S_WAIT_COUNT: begin
          if (!cmd.empty) begin
            cmd_deq <= 1'b1;
            settle  <= 1'b0;
            state   <= S_LATCH_COUNT;
          end
        end
        S_LATCH_COUNT: begin
          settle <= 1'b1;
          if (settle) begin
            beats   <= cmd.data;
            deq_cnt <= '0;
            state   <= (cmd.data == '0) ? S_WAIT_SIZE : S_STREAM;  // zero ends the matrix
          end
        end
        S_STREAM: begin
          if ((deq_cnt == beats) && !d_b_deq) begin   // last beat issued
            drain_cnt <= '0;
            state     <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (int'(drain_cnt) == DRAIN_LAST) begin
            state <= S_REPORT;
          end
        end
        S_REPORT: begin
          if (!stat_full) begin           // only back-pressure point
            stat_enq <= 1'b1;
            state    <= S_WAIT_COUNT;
          end
        end
        default: state <= S_WAIT_SIZE;
      endcase
    end
  end

  // elapsed cycles since the size was taken
  always_ff @(posedge CLK) begin
    if (RST) begin
      cycle_cnt <= '0;
    end else if ((state == S_LATCH_SIZE) && settle) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // ------------------------------
  // beat issue
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      d_b_deq  <= 1'b0;
      beat_vld <= 1'b0;
    end else begin
      d_b_deq  <= b_deq;
      beat_vld <= d_b_deq;
    end
  end

  always_ff @(posedge CLK) begin
    d_last    <= (rd_addr == last_addr);  // final beat of the row
    beat_last <= d_last;
    beat_a    <= a_q;
    beat_b    <= b.data;
    if (state == S_REPORT) begin
      stat_data <= cycle_cnt;
    end
  end

  assign beat = '{valid: beat_vld, a: beat_a, b: beat_b, last: beat_last};
  assign stat = '{data: stat_data, enq: stat_enq};

  // stream stays honest towards the B source
  a_b_deq_not_empty: assert property (@(posedge CLK) disable iff (RST)
    b_deq |-> !b.empty);

  // pops are spaced so the channel settles between them
  a_cmd_deq_pulse: assert property (@(posedge CLK) disable iff (RST)
    cmd_deq |=> !cmd_deq);

endmodule

// File: dot_engine/simd_mac_lanes.sv
`timescale 1ns/1ps
`include "mm_config.svh"

module simd_mac_lanes (
  input  logic               CLK,
  input  logic               RST,
  input  mm_pkg::beat_s      beat,
  output mm_pkg::lane_sums_s sums
);

  mm_pkg::vec_t          lane_prod;        // low words of the signed products
  mm_pkg::vec_t          prod_pipe [`MULT_LAT];
  logic [`MULT_LAT-1:0]  vld_pipe;
  logic [`MULT_LAT-1:0]  last_pipe;
  mm_pkg::vec_t          acc;              // running row sums
  mm_pkg::vec_t          sum_q;
  logic                  sum_vld;
  mm_pkg::vec_t          prod_out;
  logic                  prod_vld;
  logic                  prod_last;

  // ------------------------------
  // multipliers
  // ------------------------------
  for (genvar i = 0; i < `SIMD_LANES; i++) begin : g_lane
    logic signed [2*`WORD_W-1:0] full;
    assign full         = $signed(beat.a[i]) * $signed(beat.b[i]);
    assign lane_prod[i] = full[`WORD_W-1:0];  // mod 2^32
  end

  always_ff @(posedge CLK) begin
    prod_pipe[0] <= lane_prod;
    for (int s = 1; s < `MULT_LAT; s++) begin
      prod_pipe[s] <= prod_pipe[s-1];
    end
  end

  // valid and last ride along the product stages
  always_ff @(posedge CLK) begin
    if (RST) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
    end else begin
      vld_pipe[0]  <= beat.valid;
      last_pipe[0] <= beat.last;
      for (int s = 1; s < `MULT_LAT; s++) begin
        vld_pipe[s]  <= vld_pipe[s-1];
        last_pipe[s] <= last_pipe[s-1];
      end
    end
  end

  assign prod_out  = prod_pipe[`MULT_LAT-1];
  assign prod_vld  = vld_pipe[`MULT_LAT-1];
  assign prod_last = last_pipe[`MULT_LAT-1];

  // ------------------------------
  // row accumulators
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      acc     <= '0;
      sum_vld <= 1'b0;
    end else begin
      sum_vld <= prod_vld && prod_last;
      if (prod_vld) begin
        for (int l = 0; l < `SIMD_LANES; l++) begin
          if (prod_last) begin
            acc[l] <= '0;                 // next row starts clean
          end else begin
            acc[l] <= acc[l] + prod_out[l];  // per lane, no carry across
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (prod_vld && prod_last) begin
      for (int l = 0; l < `SIMD_LANES; l++) begin
        sum_q[l] <= acc[l] + prod_out[l];
      end
    end
  end

  assign sums = '{valid: sum_vld, sums: sum_q};

  // back-to-back totals only for one-beat rows, i.e. N equal to the lane count
  if (`SIMD_LANES > 1) begin : g_chk
    a_single_beat_rows: assert property (@(posedge CLK) disable iff (RST)
      sums.valid ##1 sums.valid |->
        $past(beat.valid && beat.last, `MULT_LAT + 1) &&
        $past(beat.valid && beat.last, `MULT_LAT + 2));
  end

endmodule

// File: dot_engine/adder_tree.sv
`timescale 1ns/1ps
`include "mm_config.svh"

// registered pairwise reduction, LOG_SIMD_LANES levels deep
module adder_tree (
  input  logic               CLK,
  input  logic               RST,
  input  mm_pkg::lane_sums_s sums,
  output mm_pkg::scalar_s    result
);

  if (`LOG_SIMD_LANES == 0) begin : g_pass
    // single lane, keep one stage of latency
    mm_pkg::word_t data_q;
    logic          vld_q;

    always_ff @(posedge CLK) begin
      if (RST) begin
        vld_q <= 1'b0;
      end else begin
        vld_q <= sums.valid;
      end
    end

    always_ff @(posedge CLK) begin
      data_q <= sums.sums[0];
    end

    assign result = '{valid: vld_q, data: data_q};
  end else begin : g_tree
    for (genvar l = 0; l < `LOG_SIMD_LANES; l++) begin : g_lvl
      localparam int NW = `SIMD_LANES >> (l + 1);  // words at this level
      logic [NW-1:0][`WORD_W-1:0] part;
      logic                       vld;

      if (l == 0) begin : g_first
        always_ff @(posedge CLK) begin
          for (int j = 0; j < NW; j++) begin
            part[j] <= sums.sums[2*j] + sums.sums[2*j+1];
          end
        end
        always_ff @(posedge CLK) begin
          if (RST) vld <= 1'b0;
          else     vld <= sums.valid;
        end
      end else begin : g_next
        always_ff @(posedge CLK) begin
          for (int j = 0; j < NW; j++) begin
            part[j] <= g_lvl[l-1].part[2*j] + g_lvl[l-1].part[2*j+1];
          end
        end
        always_ff @(posedge CLK) begin
          if (RST) vld <= 1'b0;
          else     vld <= g_lvl[l-1].vld;
        end
      end
    end

    assign result = '{valid: g_lvl[`LOG_SIMD_LANES-1].vld,
                      data:  g_lvl[`LOG_SIMD_LANES-1].part[0]};
  end

endmodule

// File: source/result_packer.sv
`timescale 1ns/1ps
`include "mm_config.svh"

module result_packer (
  input  logic              CLK,
  input  logic              RST,
  input  mm_pkg::scalar_s   result,
  input  logic              new_matrix,
  output mm_pkg::c_write_s  c_wr
);

  localparam int LAST_SLOT = `SIMD_LANES - 1;

  logic [`LOG_SIMD_LANES:0] cnt;            // scalars held so far
  logic [`ADDR_W-1:0]       next_addr;
  logic [`ADDR_W-1:0]       wr_addr;
  logic                     wr_en;
  logic                     word_done;
  mm_pkg::vec_t             shift_q;

  assign word_done = result.valid && (int'(cnt) == LAST_SLOT);

  // ------------------------------
  // count and address
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      cnt       <= '0;
      next_addr <= '0;
      wr_addr   <= '0;
      wr_en     <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (new_matrix) begin              // C restarts at word 0
        cnt       <= '0;
        next_addr <= '0;
      end else if (result.valid) begin
        if (word_done) begin
          cnt       <= '0;
          wr_en     <= 1'b1;
          wr_addr   <= next_addr;
          next_addr <= next_addr + 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // newest scalar enters at the top, so after a full word the first sits in lane 0
  always_ff @(posedge CLK) begin
    if (result.valid) begin
      shift_q <= {result.data, shift_q[`SIMD_LANES-1:1]};
    end
  end

  assign c_wr = '{we: wr_en, addr: wr_addr, data: shift_q};

  a_c_we_pulse: assert property (@(posedge CLK) disable iff (RST)
    c_wr.we |=> !c_wr.we);

endmodule

// File: source/mm_top.sv
`timescale 1ns/1ps

// dot-product engine top: fetch -> mac lanes -> reduction -> C packing
module mm_top (
  input  logic              CLK,
  input  logic              RST,

  // command / status channel
  input  mm_pkg::cmd_s      cmd,
  output logic              cmd_deq,
  output mm_pkg::stat_s     stat,
  input  logic              stat_full,

  // operand and result ports
  input  mm_pkg::a_load_s   a_load,
  input  mm_pkg::b_stream_s b,
  output logic              b_deq,
  output mm_pkg::c_write_s  c_wr
);

  mm_pkg::beat_s      beat;               // fetch -> lanes
  mm_pkg::lane_sums_s sums;               // lanes -> tree
  mm_pkg::scalar_s    result;             // tree -> packer
  logic               new_matrix;         // restarts C addressing

  // ------------------------------
  // input side
  // ------------------------------
  operand_fetch u_operand_fetch (
    .CLK        (CLK),
    .RST        (RST),
    .cmd        (cmd),
    .cmd_deq    (cmd_deq),
    .stat       (stat),
    .stat_full  (stat_full),
    .a_load     (a_load),
    .b          (b),
    .b_deq      (b_deq),
    .beat       (beat),
    .new_matrix (new_matrix)
  );

  // ------------------------------
  // dot engine
  // ------------------------------
  simd_mac_lanes u_simd_mac_lanes (
    .CLK  (CLK),
    .RST  (RST),
    .beat (beat),
    .sums (sums)
  );

  adder_tree u_adder_tree (
    .CLK    (CLK),
    .RST    (RST),
    .sums   (sums),
    .result (result)
  );

  // ------------------------------
  // output side
  // ------------------------------
  result_packer u_result_packer (
    .CLK        (CLK),
    .RST        (RST),
    .result     (result),
    .new_matrix (new_matrix),
    .c_wr       (c_wr)
  );

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

// free-running testbench clock and power-on reset
module clock_gen (
  output logic CLK,
  output logic RST
);

  localparam real HALF_PERIOD = 2.0;      // 4 ns clock

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    RST = 1'b1;
    repeat (16) @(posedge CLK);
    @(negedge CLK);                       // release away from the active edge
    RST = 1'b0;
  end

endmodule

// File: tb/mm_tb.sv
`timescale 1ns/1ps
`include "mm_config.svh"

module mm_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int MODE_SMALL  = 0;
  localparam int MODE_MIXED  = 1;
  localparam int MODE_RANDOM = 2;
  localparam int NUM_CASES   = 5;

  typedef struct packed {
    int   n;                              // matrix size as a multiple of the lane count
    int   rows;                           // B rows as a multiple of the lane count
    int   mode;                           // operand values
    int   counts;                         // beat-count commands the rows are split over
    logic gap;                            // random holes in the B stream
    logic stall;                          // random stat_full
  } test_case_t;

  // ------------------------------
  // stimulus table
  // ------------------------------
  localparam test_case_t CASES [NUM_CASES] = '{
    '{4,  4, MODE_SMALL,  1, 1'b0, 1'b0},   // one-beat rows
    '{16, 8, MODE_MIXED,  2, 1'b0, 1'b0},
    '{8,  4, MODE_RANDOM, 1, 1'b1, 1'b0},
    '{32, 8, MODE_RANDOM, 2, 1'b1, 1'b1},
    '{12, 4, MODE_MIXED,  1, 1'b0, 1'b1}    // three beats per row
  };

  logic CLK;
  logic RST;

  mm_pkg::cmd_s      cmd       = '{data: '0, empty: 1'b1};
  logic              cmd_deq;
  mm_pkg::stat_s     stat;
  logic              stat_full = 1'b0;
  mm_pkg::a_load_s   a_load    = '0;
  mm_pkg::b_stream_s b         = '{data: '0, empty: 1'b1};
  logic              b_deq;
  mm_pkg::c_write_s  c_wr;

  integer seed = 29;
  int     fail_cnt  = 0;                  // wrong values
  int     other_cnt = 0;                  // protocol or bookkeeping faults
  int     c_seen    = 0;
  int     stat_seen = 0;
  logic   gap_on    = 1'b0;
  logic   stall_on  = 1'b0;
  logic   b_taken   = 1'b0;               // b_deq seen at the last edge
  logic   stat_full_q = 1'b0;             // stat_full seen at the last edge

  mm_pkg::word_t    cmd_q [$];            // command channel contents
  mm_pkg::vec_t     b_q [$];              // B beats not yet taken
  mm_pkg::c_write_s exp_c [$];            // C words still due
  mm_pkg::word_t    stat_beats [$];       // beats of each count awaiting status

  clock_gen u_clock_gen (.CLK(CLK), .RST(RST));

  mm_top dut (
    .CLK       (CLK),
    .RST       (RST),
    .cmd       (cmd),
    .cmd_deq   (cmd_deq),
    .stat      (stat),
    .stat_full (stat_full),
    .a_load    (a_load),
    .b         (b),
    .b_deq     (b_deq),
    .c_wr      (c_wr)
  );

  // ------------------------------
  // helpers and compare tasks
  // ------------------------------
  function automatic mm_pkg::word_t gen_value(input int mode, input int r, input int j,
                                              input bit is_a);
    mm_pkg::word_t v;
    case (mode)
      MODE_SMALL: v = is_a ? (j % 7) + 1 : ((r + 2 * j) % 5) + 1;
      MODE_MIXED: begin
        // magnitudes chosen so products overflow 32 bits
        if (is_a) v = (j % 2) ? -(70000 + j * 911) : 65537 * (j + 1);
        else      v = ((r + j) % 3 == 0) ? -(4099 * (r + 1) + j) : 300007 + r * 17 + j;
      end
      default:    v = $random(seed);
    endcase
    return v;
  endfunction

  function automatic int run_budget();
    int cyc;
    cyc = 16 + 64;                        // reset and final settle
    for (int c = 0; c < NUM_CASES; c++) begin
      cyc += CASES[c].n / `SIMD_LANES + CASES[c].rows * (CASES[c].n / `SIMD_LANES) * 4;
      cyc += CASES[c].counts * 64 + 32;   // drain, stall and command overhead
    end
    return cyc * 4;                       // safety factor
  endfunction

  task automatic check_c_word(input mm_pkg::c_write_s exp, input mm_pkg::c_write_s got);
    c_seen++;
    if (got.addr !== exp.addr || got.data !== exp.data) begin
      fail_cnt++;
      $display("FAIL %0t: C write addr %0d data %h, expected addr %0d data %h",
               $time, got.addr, got.data, exp.addr, exp.data);
    end
  endtask

  task automatic check_status(input mm_pkg::word_t got, input mm_pkg::word_t beats);
    stat_seen++;
    if (got <= beats) begin
      fail_cnt++;
      $display("FAIL %0t: status of %0d cycles is not above the %0d beats of its count",
               $time, got, beats);
    end
  endtask

  // ------------------------------
  // channel models
  // ------------------------------
  always @(posedge CLK) begin
    if (!RST && b_deq && b.empty) begin   // stream pulled during a hole
      other_cnt++;
      $display("error at %0t: b_deq high while the B stream showed empty", $time);
    end
    b_taken     <= b_deq;
    stat_full_q <= stat_full;
  end

  always @(negedge CLK) begin
    if (cmd_deq) begin                    // popped word stays on data until the next pop
      if (cmd_q.size() == 0) begin
        other_cnt++;
        $display("error at %0t: command popped while the channel was empty", $time);
      end else begin
        cmd.data = cmd_q.pop_front();
      end
    end
    cmd.empty = (cmd_q.size() == 0);
    if (b_taken) begin                    // data follows the deq cycle
      if (b_q.size() == 0) begin
        other_cnt++;
        $display("error at %0t: B beat taken while the stream had none", $time);
      end else begin
        b.data = b_q.pop_front();
      end
    end
    b.empty   = (b_q.size() == 0) || (gap_on && (($random(seed) & 3) == 0));
    stat_full = stall_on && (($random(seed) & 3) != 0);
  end

  // result monitor
  always @(negedge CLK) begin
    if (!RST && c_wr.we) begin
      if (exp_c.size() == 0) begin
        other_cnt++;
        $display("error at %0t: C write to addr %0d with no word due", $time, c_wr.addr);
      end else begin
        check_c_word(exp_c.pop_front(), c_wr);
      end
    end
    if (!RST && stat.enq) begin
      if (stat_full_q) begin
        other_cnt++;
        $display("error at %0t: status pushed while stat_full was high", $time);
      end
      if (stat_beats.size() == 0) begin
        other_cnt++;
        $display("error at %0t: status word with no count outstanding", $time);
      end else begin
        check_status(stat.data, stat_beats.pop_front());
      end
    end
  end

  // ------------------------------
  // one table entry
  // ------------------------------
  task automatic run_case(input test_case_t tc);
    mm_pkg::word_t    a_vals [];
    mm_pkg::word_t    b_vals [];
    mm_pkg::word_t    acc;
    mm_pkg::vec_t     beat;
    mm_pkg::c_write_s cw;
    longint           prod;
    int               words;
    int               part;
    words  = tc.n / `SIMD_LANES;
    part   = tc.rows / tc.counts * words; // beats per count
    a_vals = new[tc.n];
    b_vals = new[tc.rows * tc.n];
    for (int j = 0; j < tc.n; j++) a_vals[j] = gen_value(tc.mode, 0, j, 1'b1);
    for (int r = 0; r < tc.rows; r++) begin
      for (int j = 0; j < tc.n; j++) b_vals[r * tc.n + j] = gen_value(tc.mode, r, j, 1'b0);
    end

    // expected C from signed products summed mod 2^32
    cw = '0;
    cw.we = 1'b1;
    for (int r = 0; r < tc.rows; r++) begin
      acc = '0;
      for (int j = 0; j < tc.n; j++) begin
        prod = longint'($signed(a_vals[j])) * longint'($signed(b_vals[r * tc.n + j]));
        acc += mm_pkg::word_t'(prod);
      end
      cw.data[r % `SIMD_LANES] = acc;     // first row of a group in lane 0
      if (r % `SIMD_LANES == `SIMD_LANES - 1) begin
        cw.addr = `ADDR_W'(r / `SIMD_LANES);
        exp_c.push_back(cw);
      end
    end

    // load A while the engine is idle
    for (int w = 0; w < words; w++) begin
      @(negedge CLK);
      a_load.we   = 1'b1;
      a_load.addr = `ADDR_W'(w);
      for (int l = 0; l < `SIMD_LANES; l++) a_load.data[l] = a_vals[w * `SIMD_LANES + l];
    end
    @(negedge CLK);
    a_load.we = 1'b0;
    @(posedge CLK);

    gap_on   = tc.gap;
    stall_on = tc.stall;
    for (int r = 0; r < tc.rows; r++) begin
      for (int k = 0; k < words; k++) begin
        for (int l = 0; l < `SIMD_LANES; l++) beat[l] = b_vals[r * tc.n + k * `SIMD_LANES + l];
        b_q.push_back(beat);
      end
    end
    cmd_q.push_back(tc.n);
    for (int c = 0; c < tc.counts; c++) begin
      cmd_q.push_back(part);
      stat_beats.push_back(part);
    end

    while (exp_c.size() != 0 || stat_beats.size() != 0) @(posedge CLK);
    gap_on   = 1'b0;
    stall_on = 1'b0;
    if (b_q.size() != 0) begin
      other_cnt++;
      $display("error: %0d B beats were never taken in the case with N = %0d", b_q.size(), tc.n);
    end
    cmd_q.push_back('0);                  // zero count ends the matrix
    while (cmd_q.size() != 0) @(posedge CLK);
    repeat (8) @(posedge CLK);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    while (RST !== 1'b0) @(posedge CLK);
    for (int c = 0; c < NUM_CASES; c++) run_case(CASES[c]);
    repeat (2 * `DRAIN_WAIT) @(posedge CLK);  // catch late duplicates
    $display("summary: %0d C words, %0d status words, %0d value errors, %0d other errors",
             c_seen, stat_seen, fail_cnt, other_cnt);
    if (fail_cnt == 0 && other_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog
  initial begin : watchdog
    int budget;
    budget = run_budget();
    #(longint'(budget) * CLK_PERIOD);
    $display("timeout after %0d cycles: %0d C words and %0d status words never arrived",
             budget, exp_c.size(), stat_beats.size());
    $display("Errors found");
    $finish;
  end

endmodule

// File: mm_top.f
+incdir+common
common/mm_pkg.sv
operand_fetch/operand_fetch.sv
dot_engine/simd_mac_lanes.sv
dot_engine/adder_tree.sv
source/result_packer.sv
source/mm_top.sv
tb/clock_gen.sv
tb/mm_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dot-product engine testbench with Verilator.
# Exit status is 0 only when the testbench prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mm_tb -f mm_top.f --Mdir obj_dir -o mm_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/mm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
